// File: hw/jag_host_pkg.sv
package jag_host_pkg;

	// ====================
	// widths
	// ====================
	typedef logic [15:0] host_word_t; // host download word
	typedef logic [24:0] host_addr_t; // host byte address
	typedef logic [5:0]  img_index_t; // image slot
	typedef logic [23:0] abus_t;      // core byte address
	typedef logic [28:0] ddr_addr_t;  // 64-bit word address into ddr
	typedef logic [63:0] ddr_data_t;
	typedef logic [7:0]  ddr_be_t;
	typedef logic [9:0]  bram_addr_t; // backup ram word address
	typedef logic [31:0] sd_lba_t;

	// ====================
	// bundles
	// ====================
	typedef struct packed {
		logic       download; // level, high for the whole image
		logic       wr;       // one-cycle strobe per word
		img_index_t index;
		host_addr_t addr;
		host_word_t data;
	} host_dl_t;

	typedef struct packed {
		ddr_addr_t addr;
		ddr_data_t data;
		ddr_be_t   be;
		logic      we;
	} ddr_wr_t;

	// core side of the save memory
	typedef struct packed {
		bram_addr_t addr;
		host_word_t data;
		logic       wr;
	} bram_port_t;

	typedef struct packed {
		logic       ack;  // high for the duration of a sector
		logic [7:0] addr; // word within the sector
		host_word_t dout; // sd -> save memory
		logic       wr;
	} sd_buf_t;

	// fixed slots and addresses
	localparam img_index_t CART_INDEX   = 6'd1;
	localparam img_index_t BIOS_INDEX_A = 6'd0;
	localparam img_index_t BIOS_INDEX_B = 6'd2;
	localparam abus_t      CART_BASE    = 24'h80_0000;
	localparam logic [7:0] DDR_REGION   = 8'b0011_0000; // jag window at 0x3000_0000
	localparam abus_t      PATCH_ADDR   = 24'h00_136E;  // beq of the checksum test
	localparam logic [7:0] PATCH_BYTE   = 8'h60;        // bra opcode

endpackage

// File: hw/cart_loader.sv
`timescale 1ns/10ps

module cart_loader import jag_host_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  host_dl_t host,
	input  logic     cart_sel,
	output ddr_wr_t  ddr,
	output logic     cart_loading
);

	logic       old_download; // for edge detect
	logic       load_wr;      // host strobe delayed by one
	abus_t      load_addr;    // byte address of next word
	host_word_t load_data;    // swapped copy of the word
	ddr_be_t    lane_be;

	// ====================
	// download tracking
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			cart_loading <= 1'b0;
			load_wr      <= 1'b0;
			load_addr    <= CART_BASE;
		end else begin
			old_download <= host.download;
			load_wr      <= host.wr & cart_sel; // ddr strobe one cycle after host strobe

			if (load_wr)
				load_addr <= load_addr + 24'd2; // one 16-bit word per strobe

			// new image always restarts at the cartridge base
			if (!old_download && host.download && cart_sel) begin
				load_addr    <= CART_BASE;
				cart_loading <= 1'b1;
			end

			if (old_download && !host.download)
				cart_loading <= 1'b0;
		end
	end

	// payload captured with the strobe, no reset needed
	always_ff @(posedge clk_sys) begin
		if (host.wr && cart_sel)
			load_data <= {host.data[7:0], host.data[15:8]}; // byte swap
	end

	// ====================
	// ddr write port
	// ====================
	// lane 0 sits in the top two bytes of the 64-bit word
	always_comb begin
		case (load_addr[2:1])
			2'd0:    lane_be = 8'b1100_0000;
			2'd1:    lane_be = 8'b0011_0000;
			2'd2:    lane_be = 8'b0000_1100;
			default: lane_be = 8'b0000_0011;
		endcase
	end

	assign ddr.addr = {DDR_REGION, load_addr[23:3]};
	assign ddr.data = {4{load_data}}; // same word on every lane
	assign ddr.be   = cart_loading ? lane_be : 8'hFF; // controller wants all set otherwise
	assign ddr.we   = load_wr;

	// host must only strobe cart words inside a download
	a_we_in_load: assert property (
		@(posedge clk_sys) disable iff (reset) ddr.we |-> cart_loading
	) else $error("ddr write strobe outside of a cartridge load");

endmodule

// File: hw/bios_rom.sv
`timescale 1ns/10ps

module bios_rom import jag_host_pkg::*; #(
	parameter int BIOS_AW = 17
) (
	input  logic       clk_sys,
	input  host_dl_t   host,
	input  logic       bios_sel,
	input  abus_t      abus,
	input  logic       patch_en,
	output logic [7:0] q
);

	logic [7:0]         mem [2**BIOS_AW]; // bios image, one byte per entry
	logic               bios_dl;          // bios download in progress
	logic               first_wr;         // low byte cycle
	logic               second_wr;        // high byte cycle, the second-byte flag
	logic [BIOS_AW-1:0] mem_addr;
	logic [BIOS_AW-1:0] rd_addr;          // registered read address
	logic [7:0]         mem_din;

	assign bios_dl = host.download & bios_sel;

	// ====================
	// write split
	// ====================
	// a host word becomes two byte writes on consecutive cycles
	always_ff @(posedge clk_sys) begin
		first_wr  <= host.wr & bios_dl;
		second_wr <= first_wr;
	end

	// host address wins while loading, lsb picks the byte
	assign mem_addr = bios_dl ? {host.addr[BIOS_AW-1:1], second_wr} : abus[BIOS_AW-1:0];
	assign mem_din  = second_wr ? host.data[15:8] : host.data[7:0];

	always_ff @(posedge clk_sys) begin
		if (first_wr || second_wr)
			mem[mem_addr] <= mem_din;
		rd_addr <= mem_addr;
	end

	// ====================
	// read with patch
	// ====================
	// beq -> bra skips the cart checksum failure
	assign q = (patch_en && rd_addr == PATCH_ADDR[BIOS_AW-1:0]) ? PATCH_BYTE : mem[rd_addr];

	// back-to-back host words would collide with the split
	a_split_gap: assert property (
		@(posedge clk_sys) second_wr |=> !second_wr
	) else $error("bios byte split overlapped the next host word");

endmodule

// File: hw/backup_store.sv
`timescale 1ns/10ps

module backup_store import jag_host_pkg::*; #(
	parameter int BK_SECTOR_BITS = 2
) (
	input  logic       clk_sys,
	input  bram_port_t bram,
	output host_word_t bram_q,
	input  sd_buf_t    sd_buf,
	input  sd_lba_t    sd_lba,
	output host_word_t sd_q
);

	localparam int AW = BK_SECTOR_BITS + 8; // sectors of 256 words

	host_word_t      mem [2**AW]; // save ram, true dual port
	logic [AW-1:0]   sd_addr;
	logic            sd_int;      // lba falls inside the save ram
	logic            sd_we;

	// sector low bits select the 256-word block
	assign sd_addr = {sd_lba[BK_SECTOR_BITS-1:0], sd_buf.addr};
	assign sd_int  = (sd_lba[31:BK_SECTOR_BITS] == '0);
	assign sd_we   = sd_int & sd_buf.wr & sd_buf.ack; // outside sectors never land

	// ====================
	// core port
	// ====================
	always @(posedge clk_sys) begin
		if (bram.wr)
			mem[bram.addr] <= bram.data;
		bram_q <= mem[bram.addr]; // one cycle read
	end

	// ====================
	// sd port
	// ====================
	always @(posedge clk_sys) begin
		if (sd_we)
			mem[sd_addr] <= sd_buf.dout;
		sd_q <= mem[sd_addr]; // feeds the sd buffer on save
	end

endmodule

// File: hw/backup_sequencer.sv
`timescale 1ns/10ps

module backup_sequencer import jag_host_pkg::*; #(
	parameter int BK_SECTOR_BITS = 2
) (
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    cart_loading,
	input  logic    core_wr,
	input  logic    sd_ack,
	input  logic    img_mounted,
	input  logic    img_readonly,
	input  logic    osd_status,
	input  logic    bk_load,
	input  logic    bk_save,
	input  logic    bk_autosave,
	output sd_lba_t sd_lba,
	output logic    sd_rd,
	output logic    sd_wr,
	output logic    busy,
	output logic    pending
);

	typedef enum logic {
		ST_IDLE,
		ST_XFER
	} bk_state_t;

	bk_state_t state;
	logic      bk_ena;       // save image mounted and writable
	logic      xfer_load;    // direction, 1 = sd -> ram
	logic      old_loading;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      save_req;
	logic      start_user;   // manual load/save or autosave
	logic      start_cart;   // end of a cartridge download

	// autosave fires once the osd is open with unsaved data
	assign save_req   = bk_save | (pending & osd_status & bk_autosave);
	assign start_user = (~old_load & bk_load) | (~old_save & save_req);
	assign start_cart = old_loading & ~cart_loading;
	assign busy       = (state == ST_XFER);

	// ====================
	// enable and pending
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena  <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (!old_loading && cart_loading)
				bk_ena <= 1'b0; // new cart, old save no longer valid
			// save file gets mounted while the cart is loading
			if (cart_loading && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (bk_ena && !osd_status && core_wr)
				pending <= 1'b1;
			else if (busy)
				pending <= 1'b0;
		end
	end

	// ====================
	// sector loop
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= ST_IDLE;
			xfer_load   <= 1'b0;
			sd_lba      <= '0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			old_loading <= 1'b0;
			old_load    <= 1'b0;
			old_save    <= 1'b0;
			old_ack     <= 1'b0;
		end else begin
			old_loading <= cart_loading;
			old_load    <= bk_load;
			old_save    <= save_req;
			old_ack     <= sd_ack;

			// request drops once the host has taken it
			if (!old_ack && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (bk_ena && (start_user || start_cart)) begin
						state     <= ST_XFER;
						xfer_load <= start_cart | bk_load; // cart end always loads
						sd_lba    <= '0;
						sd_rd     <= start_cart | bk_load;
						sd_wr     <= ~(start_cart | bk_load);
					end
				end
				ST_XFER: begin
					if (old_ack && !sd_ack) begin // sector done
						if (&sd_lba[BK_SECTOR_BITS-1:0]) begin
							state  <= ST_IDLE;
							sd_lba <= '0;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= xfer_load;
							sd_wr  <= ~xfer_load;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ack already high at the start would leave the request standing
	a_req_in_xfer: assert property (
		@(posedge clk_sys) disable iff (reset) (sd_rd || sd_wr) |-> busy
	) else $error("sd request outside a backup transfer");

endmodule

// File: hw/jag_host_glue.sv
`timescale 1ns/10ps

module jag_host_glue import jag_host_pkg::*; #(
	parameter int BIOS_AW        = 17,
	parameter int BK_SECTOR_BITS = 2
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  host_dl_t   host,
	output ddr_wr_t    ddr,
	input  abus_t      abus,
	output logic [7:0] bios_q,
	input  logic       patch_en,
	input  bram_port_t bram,
	output host_word_t bram_q,
	input  sd_buf_t    sd_buf,
	output host_word_t sd_buff_din,
	output sd_lba_t    sd_lba,
	output logic       sd_rd,
	output logic       sd_wr,
	input  logic       img_mounted,
	input  logic       img_readonly,
	input  logic       osd_status,
	input  logic       bk_load,
	input  logic       bk_save,
	input  logic       bk_autosave,
	output logic       led_user
);

	logic cart_sel;     // index is the cartridge slot
	logic bios_sel;     // index is one of the bios slots
	logic cart_loading;
	logic bk_busy;
	logic bk_pending;

	// ====================
	// index decode
	// ====================
	assign cart_sel = (host.index == CART_INDEX);
	assign bios_sel = (host.index == BIOS_INDEX_A) || (host.index == BIOS_INDEX_B);

	// lit during any download, transfer or unsaved data
	assign led_user = host.download | bk_busy | bk_pending;

	cart_loader cart_loader_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.host         (host),
		.cart_sel     (cart_sel),
		.ddr          (ddr),
		.cart_loading (cart_loading)
	);

	bios_rom #(.BIOS_AW(BIOS_AW)) bios_rom_i (
		.clk_sys  (clk_sys),
		.host     (host),
		.bios_sel (bios_sel),
		.abus     (abus),
		.patch_en (patch_en),
		.q        (bios_q)
	);

	// ====================
	// backup ram
	// ====================
	backup_store #(.BK_SECTOR_BITS(BK_SECTOR_BITS)) backup_store_i (
		.clk_sys (clk_sys),
		.bram    (bram),
		.bram_q  (bram_q),
		.sd_buf  (sd_buf),
		.sd_lba  (sd_lba),
		.sd_q    (sd_buff_din)
	);

	backup_sequencer #(.BK_SECTOR_BITS(BK_SECTOR_BITS)) backup_sequencer_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_loading (cart_loading),
		.core_wr      (bram.wr),
		.sd_ack       (sd_buf.ack),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.osd_status   (osd_status),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.bk_autosave  (bk_autosave),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.busy         (bk_busy),
		.pending      (bk_pending)
	);

endmodule

// File: test/tb_jag_host_glue.sv
`timescale 1ns/10ps

module tb_jag_host_glue import jag_host_pkg::*; ();

	localparam int          MAX_CYCLES = 6000;          // the whole run needs well under 600
	localparam logic [31:0] LFSR_SEED  = 32'd85800;
	localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

	logic       clk_sys;
	logic       reset;
	host_dl_t   host;
	ddr_wr_t    ddr;
	abus_t      abus;
	logic [7:0] bios_q;
	logic       patch_en;
	bram_port_t bram;
	host_word_t bram_q;
	sd_buf_t    sd_buf;
	host_word_t sd_buff_din;
	sd_lba_t    sd_lba;
	logic       sd_rd, sd_wr;
	logic       img_mounted, img_readonly, osd_status;
	logic       bk_load, bk_save, bk_autosave;
	logic       led_user;

	logic [31:0] lfsr;
	int          err_cnt, chk_cnt, err_mark, chk_mark, tests_ok, tests_bad;
	string       test_name;
	abus_t       exp_addr;          // model of the cart load address
	ddr_wr_t     exp_ddr;
	logic        bios_chk, bram_chk, led_chk, sd_chk;
	logic [7:0]  exp_byte;
	host_word_t  exp_word;
	host_word_t  exp_sd;            // sd port word on save
	logic        exp_led;
	logic        exp_wr;            // 1 = save expected
	sd_lba_t     xfer_req;          // sectors served in this transfer
	host_word_t  exp_mem [1024];    // what the sd model streamed

	jag_host_glue #(.BIOS_AW(17), .BK_SECTOR_BITS(2)) dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ====================
	// checks
	// ====================
	a_ddr_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		host.wr && host.index == CART_INDEX |=> ddr.we)
	else begin
		err_cnt++;
		$display("%s: cartridge word gave no ddr write strobe", test_name);
	end

	a_ddr_value: assert property (@(posedge clk_sys) disable iff (reset)
		ddr.we |-> ddr == exp_ddr)
	else begin
		err_cnt++;
		$display("error %s expected %h actual %h", test_name, exp_ddr, $sampled(ddr));
	end

	a_bios_byte: assert property (@(posedge clk_sys) bios_chk |-> bios_q == exp_byte)
	else begin
		err_cnt++;
		$display("error %s expected %h actual %h", test_name, exp_byte, $sampled(bios_q));
	end

	// kth request of a transfer carries lba k
	a_sd_request: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_rd || sd_wr) |-> {sd_wr, sd_lba} == {exp_wr, xfer_req})
	else begin
		err_cnt++;
		$display("error %s expected %h actual %h", test_name, {exp_wr, xfer_req},
			{$sampled(sd_wr), $sampled(sd_lba)});
	end

	a_xfer_end: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(dut_i.bk_busy) |-> xfer_req == 4)
	else begin
		err_cnt++;
		$display("error %s expected 4 actual %0d sectors", test_name, xfer_req);
	end

	a_bram_word: assert property (@(posedge clk_sys) bram_chk |-> bram_q == exp_word)
	else begin
		err_cnt++;
		$display("error %s expected %h actual %h", test_name, exp_word, $sampled(bram_q));
	end

	a_sd_word: assert property (@(posedge clk_sys) disable iff (reset)
		sd_chk |-> sd_buff_din == exp_sd)
	else begin
		err_cnt++;
		$display("error %s expected %h actual %h", test_name, exp_sd, $sampled(sd_buff_din));
	end

	a_led: assert property (@(posedge clk_sys) disable iff (reset) led_chk |-> led_user == exp_led)
	else begin
		err_cnt++;
		$display("error %s expected %b actual %b", test_name, exp_led, $sampled(led_user));
	end

	// ====================
	// helpers
	// ====================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic rand_word(output host_word_t w);
		w = '0;
		repeat (16) begin
			w = {w[14:0], lfsr[0]}; // one step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_mark = err_cnt;
		chk_mark = chk_cnt;
	endtask

	task automatic end_test();
		repeat (2) @(negedge clk_sys); // let late failures land
		if (chk_cnt == chk_mark) begin
			err_cnt++;
			$display("%s: no check was reached", test_name);
		end
		if (err_cnt == err_mark) begin
			tests_ok++;
			$display("test %s passed", test_name);
		end else begin
			tests_bad++;
			$display("test %s failed with %0d errors", test_name, err_cnt - err_mark);
		end
	endtask

	task automatic host_write(input host_addr_t a, input host_word_t d);
		host.addr = a;
		host.data = d;
		host.wr = 1'b1;
		@(negedge clk_sys);
		host.wr = 1'b0;
		repeat (2) @(negedge clk_sys); // two idle cycles per word
	endtask

	task automatic dl_begin(input img_index_t idx);
		host.index = idx;
		host.download = 1'b1;
		if (idx == CART_INDEX)
			exp_addr = CART_BASE;
		@(negedge clk_sys);
	endtask

	task automatic dl_end();
		host.download = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	// expected strobe built from the lane rule, lane 0 in the top bytes
	task automatic cart_word(input host_word_t w);
		exp_ddr = '{addr: {DDR_REGION, exp_addr[23:3]}, data: {4{w[7:0], w[15:8]}},
			be: 8'b1100_0000 >> (2 * exp_addr[2:1]), we: 1'b1};
		chk_cnt++;
		host_write('0, w);
		exp_addr = exp_addr + 24'd2;
	endtask

	task automatic bios_read(input abus_t a, input logic pen, input logic [7:0] b);
		abus = a;
		patch_en = pen;
		@(negedge clk_sys); // address registered
		exp_byte = b;
		bios_chk = 1'b1;
		chk_cnt++;
		@(negedge clk_sys);
		bios_chk = 1'b0;
	endtask

	task automatic bram_read(input bram_addr_t a, input host_word_t w);
		bram.addr = a;
		@(negedge clk_sys);
		exp_word = w;
		bram_chk = 1'b1;
		chk_cnt++;
		@(negedge clk_sys);
		bram_chk = 1'b0;
	endtask

	task automatic led_check(input logic v);
		exp_led = v;
		led_chk = 1'b1;
		chk_cnt++;
		@(negedge clk_sys);
		led_chk = 1'b0;
	endtask

	task automatic wait_xfer();
		int n;
		n = 0;
		while (!dut_i.bk_busy && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (!dut_i.bk_busy) begin
			err_cnt++;
			$display("%s: backup transfer did not start", test_name);
		end
		while (dut_i.bk_busy)
			@(negedge clk_sys); // bounded by the watchdog
	endtask

	// ====================
	// sd host model
	// ====================
	initial begin : sd_model
		sd_lba_t    lba;
		logic       is_load;
		host_word_t w;
		sd_buf = '0;
		sd_chk = 1'b0;
		exp_sd = '0;
		forever begin
			@(negedge clk_sys);
			sd_chk = 1'b0;
			if (sd_rd || sd_wr) begin
				lba = sd_lba;
				is_load = sd_rd; // request drops once ack is seen
				chk_cnt++;
				sd_buf.ack = 1'b1;
				for (int k = 0; k < 8; k++) begin
					sd_buf.addr = k[7:0];
					if (is_load) begin
						rand_word(w);
						sd_buf.dout = w;
						sd_buf.wr = 1'b1;
						exp_mem[{lba[1:0], k[7:0]}] = w;
					end else if (k > 0) begin
						// save word trails the buffer address by a cycle
						exp_sd = exp_mem[{lba[1:0], k[7:0] - 8'd1}];
						sd_chk = 1'b1;
						chk_cnt++;
					end
					@(negedge clk_sys);
				end
				sd_buf.ack = 1'b0; // sector ends on ack fall
				sd_buf.wr = 1'b0;
				if (!is_load) begin
					exp_sd = exp_mem[{lba[1:0], 8'd7}];
					sd_chk = 1'b1;
					chk_cnt++;
				end
				xfer_req = xfer_req + 32'd1;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("run did not finish within %0d cycles", MAX_CYCLES);
		$display("Errors found");
		$finish;
	end

	// ====================
	// stimulus
	// ====================
	initial begin : stimulus
		host = '0;
		abus = '0;
		patch_en = 1'b0;
		bram = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		osd_status = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		bk_autosave = 1'b0;
		bios_chk = 1'b0;
		bram_chk = 1'b0;
		led_chk = 1'b0;
		exp_led = 1'b0;
		exp_wr = 1'b0;
		exp_byte = '0;
		exp_word = '0;
		xfer_req = '0;
		exp_ddr = '0;
		exp_addr = CART_BASE;
		lfsr = LFSR_SEED;
		err_cnt = 0;
		chk_cnt = 0;
		tests_ok = 0;
		tests_bad = 0;
		reset = 1'b1;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		start_test("cart_writes");
		dl_begin(CART_INDEX);
		cart_word(16'h1234);
		cart_word(16'hABCD);
		cart_word(16'h5566);
		cart_word(16'h0F0F);
		cart_word(16'h7788); // next 64-bit word, lane 0 again
		end_test();

		start_test("download_restart");
		dl_end();
		dl_begin(CART_INDEX); // address back to the base
		cart_word(16'hC0DE);
		dl_end();
		end_test();

		start_test("bios_load_read");
		dl_begin(BIOS_INDEX_A);
		host_write(25'h00100, 16'hBEEF);
		host_write({1'b0, PATCH_ADDR}, 16'h1267);
		dl_end();
		bios_read(24'h000100, 1'b0, 8'hEF); // low byte at the even address
		bios_read(24'h000101, 1'b0, 8'hBE);
		bios_read(PATCH_ADDR, 1'b0, 8'h67);
		bios_read(PATCH_ADDR, 1'b1, PATCH_BYTE);
		bios_read(PATCH_ADDR + 24'd1, 1'b1, 8'h12); // neighbour untouched
		end_test();

		// save image mounted during the cart, cart end pulls it in
		start_test("load_after_cart");
		xfer_req = '0;
		exp_wr = 1'b0;
		dl_begin(CART_INDEX);
		repeat (2) @(negedge clk_sys); // enable clear at load start
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		dl_end();
		wait_xfer();
		for (int s = 0; s < 4; s++)
			for (int k = 0; k < 8; k++)
				bram_read(bram_addr_t'(s * 256 + k), exp_mem[{s[1:0], k[7:0]}]);
		end_test();

		start_test("manual_save");
		xfer_req = '0;
		exp_wr = 1'b1;
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		wait_xfer();
		end_test();

		start_test("pending_autosave");
		led_check(1'b0);
		bram.addr = 10'h003;
		bram.data = 16'h5A5A;
		bram.wr = 1'b1;
		exp_mem[10'h003] = 16'h5A5A; // goes back out in sector 0
		@(negedge clk_sys);
		bram.wr = 1'b0;
		led_check(1'b1); // lit by pending
		xfer_req = '0;
		exp_wr = 1'b1;
		bk_autosave = 1'b1;
		osd_status = 1'b1;
		wait_xfer();
		led_check(1'b0); // pending gone after the save
		bk_autosave = 1'b0;
		osd_status = 1'b0;
		end_test();

		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
			tests_ok, tests_bad, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: jag_host_glue.f
hw/jag_host_pkg.sv
hw/cart_loader.sv
hw/bios_rom.sv
hw/backup_store.sv
hw/backup_sequencer.sv
hw/jag_host_glue.sv
test/tb_jag_host_glue.sv

// File: Bender.yml
package:
  name: jag_host_glue

sources:
  - hw/jag_host_pkg.sv
  - hw/cart_loader.sv
  - hw/bios_rom.sv
  - hw/backup_store.sv
  - hw/backup_sequencer.sv
  - hw/jag_host_glue.sv
  - target: test
    files:
      - test/tb_jag_host_glue.sv
